/* serv_rf.f */
serv_rf_pkg.sv
serv_rf_nibble_ram.sv
serv_rf_phase_counter.sv
serv_rf_write_ctrl.sv
serv_rf_write_shift.sv
serv_rf_read_ctrl.sv
serv_rf_read_shift.sv
serv_rf.sv
tb_serv_rf.sv

/* serv_rf.sv */
`timescale 1ns/1ns

module serv_rf (
   input  logic                 i_clk,
   input  logic                 i_rst,
   input  serv_rf_pkg::wr_req_t i_wr,
   input  logic                 i_rd,
   input  logic                 i_csr,
   input  logic                 i_mepc,
   input  logic                 i_mtval,
   input  serv_rf_pkg::rd_req_t i_rd_req,
   output logic                 o_rgnt,
   output logic                 o_rs1,
   output logic                 o_rs2,
   output logic                 o_csr
);

   import serv_rf_pkg::*;

   // Write side
   logic      wr_start;
   slot_t     wr_slot;
   nib_idx_t  wr_nib;
   logic      wr_last;
   logic      wr_en;
   ram_addr_t wr_addr;
   nibble_t   wr_data;
   ram_wr_t   ram_wr;

   // Read side
   logic      rd_start;
   slot_t     rd_slot;
   nib_idx_t  rd_nib;
   ram_addr_t rd_addr;
   nibble_t   rd_data;

   serv_rf_write_ctrl u_wctrl (
      .i_clk   (i_clk),
      .i_rst   (i_rst),
      .i_wr    (i_wr),
      .i_slot  (wr_slot),
      .i_nib   (wr_nib),
      .i_last  (wr_last),
      .o_start (wr_start),
      .o_wen   (wr_en),
      .o_waddr (wr_addr)
   );

   serv_rf_phase_counter u_wcnt (
      .i_clk   (i_clk),
      .i_rst   (i_rst),
      .i_start (wr_start),
      .o_slot  (wr_slot),
      .o_nib   (wr_nib),
      .o_last  (wr_last)
   );

   serv_rf_write_shift u_wshift (
      .i_clk    (i_clk),
      .i_rd     (i_rd),
      .i_csr    (i_csr),
      .i_mepc   (i_mepc),
      .i_mtval  (i_mtval),
      .i_slot   (wr_slot),
      .o_nibble (wr_data)
   );

   assign ram_wr = '{en: wr_en, addr: wr_addr, data: wr_data};

   serv_rf_read_ctrl u_rctrl (
      .i_clk   (i_clk),
      .i_rst   (i_rst),
      .i_req   (i_rd_req),
      .i_slot  (rd_slot),
      .i_nib   (rd_nib),
      .o_start (rd_start),
      .o_rgnt  (o_rgnt),
      .o_raddr (rd_addr)
   );

   // Read end is tracked by the controller itself
   serv_rf_phase_counter u_rcnt (
      .i_clk   (i_clk),
      .i_rst   (i_rst),
      .i_start (rd_start),
      .o_slot  (rd_slot),
      .o_nib   (rd_nib),
      .o_last  ()
   );

   serv_rf_read_shift u_rshift (
      .i_clk   (i_clk),
      .i_slot  (rd_slot),
      .i_rdata (rd_data),
      .o_rs1   (o_rs1),
      .o_rs2   (o_rs2),
      .o_csr   (o_csr)
   );

   serv_rf_nibble_ram u_ram (
      .i_clk   (i_clk),
      .i_wr    (ram_wr),
      .i_raddr (rd_addr),
      .o_rdata (rd_data)
   );

endmodule

/* serv_rf_nibble_ram.sv */
`timescale 1ns/1ns

module serv_rf_nibble_ram (
   input  logic                  i_clk,
   input  serv_rf_pkg::ram_wr_t  i_wr,
   input  serv_rf_pkg::ram_addr_t i_raddr,
   output serv_rf_pkg::nibble_t  o_rdata
);

   import serv_rf_pkg::*;

   // 32 GPRs and four CSRs, eight nibbles each
   nibble_t mem [0:511];

   always_ff @(posedge i_clk) begin
      if (i_wr.en) begin
         mem[i_wr.addr] <= i_wr.data;
      end
      o_rdata <= mem[i_raddr];
   end

   a_waddr_known: assert property (
      @(posedge i_clk) i_wr.en |-> !$isunknown(i_wr.addr)
   ) else $error("RAM write with unknown address");

endmodule

/* serv_rf_phase_counter.sv */
`timescale 1ns/1ns

module serv_rf_phase_counter (
   input  logic                  i_clk,
   input  logic                  i_rst,
   input  logic                  i_start,
   output serv_rf_pkg::slot_t    o_slot,
   output serv_rf_pkg::nib_idx_t o_nib,
   output logic                  o_last
);

   import serv_rf_pkg::*;

   slot_t    slot_q;
   nib_idx_t nib_q;

   // One-hot ring, empty until the first start
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         slot_q <= '0;
      end else if (i_start) begin
         slot_q <= 4'b0001;
      end else begin
         slot_q <= {slot_q[2:0], slot_q[3]};
      end
   end

   // Step to the next nibble once all four slots have had their turn
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         nib_q <= '0;
      end else if (i_start) begin
         nib_q <= '0;
      end else if (slot_q[3]) begin
         nib_q <= nib_q + 3'd1;
      end
   end

   assign o_slot = slot_q;
   assign o_nib  = nib_q;
   assign o_last = slot_q[3] && (nib_q == 3'd7);

endmodule

/* serv_rf_pkg.sv */
package serv_rf_pkg;

   // General register number
   typedef logic [4:0] reg_addr_t;

   // RAM address
   // GPR {1'b0, reg[4:0], nib[2:0]}
   // CSR {1'b1, 3'b000, csr[1:0], nib[2:0]}
   typedef logic [8:0] ram_addr_t;

   typedef logic [3:0] nibble_t;

   // Nibble 0 holds bits 3..0
   typedef logic [2:0] nib_idx_t;

   // One-hot slot within a four-cycle group
   typedef logic [3:0] slot_t;

   typedef enum logic [1:0] {
      CSR_MSCRATCH = 2'd0,
      CSR_MTVEC    = 2'd1,
      CSR_MEPC     = 2'd2,
      CSR_MTVAL    = 2'd3
   } csr_slot_t;

   typedef enum logic [1:0] {
      WR_IDLE,
      WR_RUN,
      WR_DRAIN
   } wr_state_t;

   typedef struct packed {
      logic      rd_en;
      logic      csr_en;
      logic      mepc_en;
      logic      mtval_en;
      reg_addr_t rd_addr;
      csr_slot_t csr_slot;
   } wr_req_t;

   typedef struct packed {
      logic      en;
      ram_addr_t addr;
      nibble_t   data;
   } ram_wr_t;

   typedef struct packed {
      logic      req;
      reg_addr_t rs1_addr;
      reg_addr_t rs2_addr;
      csr_slot_t csr_slot;
   } rd_req_t;

endpackage

/* serv_rf_read_ctrl.sv */
`timescale 1ns/1ns

module serv_rf_read_ctrl (
   input  logic                   i_clk,
   input  logic                   i_rst,
   input  serv_rf_pkg::rd_req_t   i_req,
   input  serv_rf_pkg::slot_t     i_slot,
   input  serv_rf_pkg::nib_idx_t  i_nib,
   output logic                   o_start,
   output logic                   o_rgnt,
   output serv_rf_pkg::ram_addr_t o_raddr
);

   import serv_rf_pkg::*;

   logic [2:0] req_dly;
   logic       busy;
   reg_addr_t  rs1_q;
   reg_addr_t  rs2_q;
   csr_slot_t  csr_q;

   assign o_start = i_req.req;

   // Fixed latency, grant leads the first data bit by one cycle
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         req_dly <= '0;
         o_rgnt  <= 1'b0;
      end else begin
         req_dly <= {req_dly[1:0], i_req.req};
         o_rgnt  <= req_dly[2];
      end
   end

   // Busy until the CSR shifter takes nibble 7
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         busy <= 1'b0;
      end else if (i_req.req) begin
         busy <= 1'b1;
      end else if (i_slot[3] && (i_nib == 3'd7)) begin
         busy <= 1'b0;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_req.req) begin
         rs1_q <= i_req.rs1_addr;
         rs2_q <= i_req.rs2_addr;
         csr_q <= i_req.csr_slot;
      end
   end

   // Slot 3 is idle and just repeats the CSR address
   always_comb begin
      if (i_slot[0]) begin
         o_raddr = {1'b0, rs1_q, i_nib};
      end else if (i_slot[1]) begin
         o_raddr = {1'b0, rs2_q, i_nib};
      end else begin
         o_raddr = {1'b1, 3'b000, csr_q, i_nib};
      end
   end

   a_req_not_busy: assert property (
      @(posedge i_clk) disable iff (i_rst)
      i_req.req |-> !busy
   ) else $error("Read request while previous read still loading");

endmodule

/* serv_rf_read_shift.sv */
`timescale 1ns/1ns

module serv_rf_read_shift (
   input  logic                 i_clk,
   input  serv_rf_pkg::slot_t   i_slot,
   input  serv_rf_pkg::nibble_t i_rdata,
   output logic                 o_rs1,
   output logic                 o_rs2,
   output logic                 o_csr
);

   import serv_rf_pkg::*;

   // Staggered depths bring all three streams out in step
   logic [5:0] rs1_sr;
   logic [4:0] rs2_sr;
   logic [3:0] csr_sr;

   always_ff @(posedge i_clk) begin
      rs1_sr[4:0] <= rs1_sr[5:1];
      rs2_sr[3:0] <= rs2_sr[4:1];
      csr_sr[2:0] <= csr_sr[3:1];

      // RAM word arrives one cycle after its slot
      if (i_slot[1]) begin
         rs1_sr[5:2] <= i_rdata;
      end
      if (i_slot[2]) begin
         rs2_sr[4:1] <= i_rdata;
      end
      if (i_slot[3]) begin
         csr_sr[3:0] <= i_rdata;
      end
   end

   assign o_rs1 = rs1_sr[0];
   assign o_rs2 = rs2_sr[0];
   assign o_csr = csr_sr[0];

endmodule

/* serv_rf_write_ctrl.sv */
`timescale 1ns/1ns

module serv_rf_write_ctrl (
   input  logic                   i_clk,
   input  logic                   i_rst,
   input  serv_rf_pkg::wr_req_t   i_wr,
   input  serv_rf_pkg::slot_t     i_slot,
   input  serv_rf_pkg::nib_idx_t  i_nib,
   input  logic                   i_last,
   output logic                   o_start,
   output logic                   o_wen,
   output serv_rf_pkg::ram_addr_t o_waddr
);

   import serv_rf_pkg::*;

   wr_state_t state;

   // Source enables in slot order: mepc, mtval, csr, rd
   logic [3:0] src_en;
   reg_addr_t  rd_addr_q;
   csr_slot_t  csr_q;
   nib_idx_t   wr_nib;
   logic       any_en;
   logic       wr_phase;

   assign any_en  = i_wr.rd_en | i_wr.csr_en | i_wr.mepc_en | i_wr.mtval_en;
   assign o_start = (state == WR_IDLE) && any_en;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         state <= WR_IDLE;
      end else begin
         case (state)
            WR_IDLE: begin
               if (o_start) begin
                  state <= WR_RUN;
               end
            end
            WR_RUN: begin
               if (i_last) begin
                  state <= WR_DRAIN;
               end
            end
            WR_DRAIN: begin
               if (i_slot[3]) begin
                  state <= WR_IDLE;
               end
            end
            default: state <= WR_IDLE;
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (o_start) begin
         src_en    <= {i_wr.rd_en, i_wr.csr_en, i_wr.mtval_en, i_wr.mepc_en};
         rd_addr_q <= i_wr.rd_addr;
         csr_q     <= i_wr.csr_slot;
      end
   end

   // Shifters hold a full nibble one group behind the counter,
   // so group 0 writes nothing and the drain group writes nibble 7
   assign wr_nib   = i_nib - 3'd1;
   assign wr_phase = ((state == WR_RUN) && (i_nib != 3'd0)) || (state == WR_DRAIN);
   assign o_wen    = wr_phase && |(src_en & i_slot);

   always_comb begin
      if (i_slot[0]) begin
         o_waddr = {1'b1, 3'b000, CSR_MEPC, wr_nib};
      end else if (i_slot[1]) begin
         o_waddr = {1'b1, 3'b000, CSR_MTVAL, wr_nib};
      end else if (i_slot[2]) begin
         o_waddr = {1'b1, 3'b000, csr_q, wr_nib};
      end else begin
         o_waddr = {1'b0, rd_addr_q, wr_nib};
      end
   end

   a_start_restart: assert property (
      @(posedge i_clk) disable iff (i_rst)
      o_start |=> (i_slot == 4'b0001) && (i_nib == 3'd0)
   ) else $error("Write counter not restarted by start");

   a_wen_slot: assert property (
      @(posedge i_clk) disable iff (i_rst)
      o_wen |-> $onehot(i_slot)
   ) else $error("RAM write enabled without a single active slot");

endmodule

/* serv_rf_write_shift.sv */
`timescale 1ns/1ns

module serv_rf_write_shift (
   input  logic                 i_clk,
   input  logic                 i_rd,
   input  logic                 i_csr,
   input  logic                 i_mepc,
   input  logic                 i_mtval,
   input  serv_rf_pkg::slot_t   i_slot,
   output serv_rf_pkg::nibble_t o_nibble
);

   import serv_rf_pkg::*;

   // Depth is 5 plus the slot number, so each low nibble
   // holds four fresh bits exactly when its slot comes round
   logic [4:0] mepc_sr;
   logic [5:0] mtval_sr;
   logic [6:0] csr_sr;
   logic [7:0] rd_sr;

   // LSB first, new bits enter at the top
   always_ff @(posedge i_clk) begin
      mepc_sr  <= {i_mepc, mepc_sr[4:1]};
      mtval_sr <= {i_mtval, mtval_sr[5:1]};
      csr_sr   <= {i_csr, csr_sr[6:1]};
      rd_sr    <= {i_rd, rd_sr[7:1]};
   end

   always_comb begin
      if (i_slot[0]) begin
         o_nibble = mepc_sr[3:0];
      end else if (i_slot[1]) begin
         o_nibble = mtval_sr[3:0];
      end else if (i_slot[2]) begin
         o_nibble = csr_sr[3:0];
      end else begin
         o_nibble = rd_sr[3:0];
      end
   end

endmodule

/* tb_serv_rf.sv */
`timescale 1ns/1ns

module tb_serv_rf;

   import serv_rf_pkg::*;

   // Writes, reads and the bare grant request
   localparam int NUM_XFERS = 60;
   localparam int WATCHDOG_CYCLES = NUM_XFERS * 48 + 400;

   logic        clk;
   logic        rst;
   wr_req_t     wr;
   logic        rd_bit;
   logic        csr_bit;
   logic        mepc_bit;
   logic        mtval_bit;
   rd_req_t     rd_req;
   logic        rgnt;
   logic        rs1;
   logic        rs2;
   logic        csr;
   logic [31:0] gpr_model [0:31];
   logic [31:0] csr_model [0:3];
   logic [31:0] rng_state;
   int          num_checks;
   int          num_errors;

   serv_rf i_serv_rf (
      .i_clk    (clk),
      .i_rst    (rst),
      .i_wr     (wr),
      .i_rd     (rd_bit),
      .i_csr    (csr_bit),
      .i_mepc   (mepc_bit),
      .i_mtval  (mtval_bit),
      .i_rd_req (rd_req),
      .o_rgnt   (rgnt),
      .o_rs1    (rs1),
      .o_rs2    (rs2),
      .o_csr    (csr)
   );

   always #2 clk = ~clk;

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
      num_checks++;
      if (act !== exp) begin
         num_errors++;
         $display("Error at %0t ns: %s expected 0x%h, got 0x%h", $time, name, exp, act);
      end
   endtask

   // en is {rd, csr, mepc, mtval}
   task automatic write_word(input logic [3:0] en, input reg_addr_t rd_a, input csr_slot_t cs,
                             input logic [31:0] rd_v, input logic [31:0] csr_v,
                             input logic [31:0] mepc_v, input logic [31:0] mtval_v);
      for (int k = 0; k < 32; k++) begin
         @(negedge clk);
         wr.rd_en    = en[3];
         wr.csr_en   = en[2];
         wr.mepc_en  = en[1];
         wr.mtval_en = en[0];
         wr.rd_addr  = rd_a;
         wr.csr_slot = cs;
         rd_bit      = rd_v[k];
         csr_bit     = csr_v[k];
         mepc_bit    = mepc_v[k];
         mtval_bit   = mtval_v[k];
      end
      @(negedge clk);
      wr        = '0;
      rd_bit    = 1'b0;
      csr_bit   = 1'b0;
      mepc_bit  = 1'b0;
      mtval_bit = 1'b0;
      repeat (8) @(negedge clk);
      if (en[3]) gpr_model[rd_a] = rd_v;
      if (en[2]) csr_model[cs] = csr_v;
      if (en[1]) csr_model[CSR_MEPC] = mepc_v;
      if (en[0]) csr_model[CSR_MTVAL] = mtval_v;
   endtask

   task automatic read_word(input reg_addr_t a1, input reg_addr_t a2, input csr_slot_t cs);
      int          cycle;
      logic [31:0] got1;
      logic [31:0] got2;
      logic [31:0] gotc;
      @(negedge clk);
      rd_req.req      = 1'b1;
      rd_req.rs1_addr = a1;
      rd_req.rs2_addr = a2;
      rd_req.csr_slot = cs;
      @(negedge clk);
      rd_req.req = 1'b0;
      cycle = 1;
      while (rgnt !== 1'b1 && cycle < 16) begin
         @(negedge clk);
         cycle++;
      end
      if (rgnt !== 1'b1) begin
         num_errors++;
         $display("No grant within 16 cycles of the read request issued before %0t ns", $time);
      end else begin
         check("o_rgnt cycle", 4, cycle);
         for (int k = 0; k < 32; k++) begin
            @(negedge clk);
            if (k == 0) check("o_rgnt", 0, rgnt);
            got1[k] = rs1;
            got2[k] = rs2;
            gotc[k] = csr;
         end
         check("o_rs1", gpr_model[a1], got1);
         check("o_rs2", gpr_model[a2], got2);
         // Unwritten CSRs are X in the RAM and the model alike
         if (!$isunknown(csr_model[cs])) check("o_csr", csr_model[cs], gotc);
      end
   endtask

   task automatic grant_timing();
      check("o_rgnt", 0, rgnt);
      @(negedge clk);
      rd_req     = '0;
      rd_req.req = 1'b1;
      for (int c = 1; c <= 6; c++) begin
         @(negedge clk);
         rd_req.req = 1'b0;
         check("o_rgnt", (c == 4), rgnt);
      end
      repeat (32) @(negedge clk);
   endtask

   task automatic gpr_pair_readback();
      write_word(4'b1000, 5'd5, CSR_MSCRATCH, 32'ha5c3_1e07, 0, 0, 0);
      write_word(4'b1000, 5'd17, CSR_MSCRATCH, 32'h5a3c_e1f8, 0, 0, 0);
      read_word(5'd5, 5'd17, CSR_MSCRATCH);
      read_word(5'd17, 5'd17, CSR_MTVEC);
   endtask

   task automatic csr_readback();
      write_word(4'b0100, 5'd0, CSR_MSCRATCH, 0, 32'hdead_0bee, 0, 0);
      write_word(4'b0100, 5'd0, CSR_MTVEC, 0, 32'h8000_0104, 0, 0);
      read_word(5'd17, 5'd5, CSR_MSCRATCH);
      read_word(5'd5, 5'd17, CSR_MTVEC);
   endtask

   task automatic combined_write();
      write_word(4'b1011, 5'd9, CSR_MSCRATCH, 32'h1234_5678, 0, 32'h0000_2ace, 32'hf00d_cafe);
      read_word(5'd9, 5'd5, CSR_MEPC);
      read_word(5'd17, 5'd9, CSR_MTVAL);
      read_word(5'd9, 5'd17, CSR_MSCRATCH);
   endtask

   task automatic random_fill();
      reg_addr_t a1;
      reg_addr_t a2;
      for (int r = 1; r < 32; r++) begin
         rng_state = xorshift32(rng_state);
         write_word(4'b1000, r[4:0], CSR_MSCRATCH, rng_state, 0, 0, 0);
      end
      for (int n = 0; n < 16; n++) begin
         rng_state = xorshift32(rng_state);
         a1 = (rng_state[4:0] == 5'd0) ? 5'd31 : rng_state[4:0];
         a2 = (rng_state[9:5] == 5'd0) ? 5'd1 : rng_state[9:5];
         read_word(a1, a2, csr_slot_t'(rng_state[11:10]));
      end
   endtask

   initial begin
      clk        = 1'b0;
      rst        = 1'b1;
      wr         = '0;
      rd_bit     = 1'b0;
      csr_bit    = 1'b0;
      mepc_bit   = 1'b0;
      mtval_bit  = 1'b0;
      rd_req     = '0;
      rng_state  = 32'd27;
      num_checks = 0;
      num_errors = 0;
      for (int i = 0; i < 32; i++) gpr_model[i] = 'x;
      for (int i = 0; i < 4; i++) csr_model[i] = 'x;
      repeat (16) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      grant_timing();
      gpr_pair_readback();
      csr_readback();
      combined_write();
      random_fill();
      repeat (4) @(negedge clk);
      $display("Checks run: %0d, errors: %0d", num_checks, num_errors);
      if (num_errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("Simulation failed");
      $finish;
   end

endmodule
